// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= l15_bridge_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
design/l15_proto_pkg.sv
design/cache_geom_pkg.sv
design/l15_request_issuer.sv
design/l15_response_decoder.sv
design/l15_bridge_top.sv
sim/l15_bridge_asserts.sv
sim/l15_bridge_tb.sv

// ==== design/cache_geom_pkg.sv ====
package cache_geom_pkg;

    localparam int PHY_ADDR_W = 40;

    // instruction cache: 32 byte lines, 128 sets
    localparam int IC_OFFSET_W     = 5;
    localparam int IC_INDEX_W      = 7;
    localparam int IC_TAG_W        = 28;
    localparam int IC_BLOCK_ADDR_W = 35;

    // data cache: 16 byte lines, 256 sets
    localparam int DC_OFFSET_W     = 4;
    localparam int DC_INDEX_W      = 8;
    localparam int DC_TAG_W        = 28;
    localparam int DC_BLOCK_ADDR_W = 36;

    localparam int IC_LINE_W  = 256;
    localparam int DC_LINE_W  = 128;
    localparam int L15_WORD_W = 64;

    typedef struct packed {
        logic [IC_TAG_W-1:0]    tag;
        logic [IC_INDEX_W-1:0]  index;
        logic [IC_OFFSET_W-1:0] offset;
    } ic_addr_t;

    typedef struct packed {
        logic [DC_TAG_W-1:0]    tag;
        logic [DC_INDEX_W-1:0]  index;
        logic [DC_OFFSET_W-1:0] offset;
    } dc_addr_t;

    // returned address, split by the cache that receives it
    typedef union packed {
        ic_addr_t ic;
        dc_addr_t dc;
    } ret_addr_u;

endpackage

// ==== design/l15_bridge_top.sv ====
`timescale 1ns/1ps

module l15_bridge_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    // core requests
    input  logic                                       ic_req_valid_i,
    input  logic [cache_geom_pkg::IC_BLOCK_ADDR_W-1:0] ic_req_block_addr_i,
    input  logic                                       dc_ld_valid_i,
    input  logic [cache_geom_pkg::DC_BLOCK_ADDR_W-1:0] dc_ld_block_addr_i,
    input  logic                                       dc_st_valid_i,
    input  logic [cache_geom_pkg::PHY_ADDR_W-1:0]      dc_st_addr_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      dc_st_data_i,
    input  l15_proto_pkg::req_size_t                   dc_st_size_i,
    // L1.5 request port
    input  logic                                       l15_ack_i,
    output logic                                       l15_val_o,
    output l15_proto_pkg::rqtype_t                     l15_rqtype_o,
    output l15_proto_pkg::req_size_t                   l15_size_o,
    output logic [cache_geom_pkg::PHY_ADDR_W-1:0]      l15_address_o,
    output logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_data_o,
    output logic                                       l15_nc_o,
    // L1.5 return port
    input  logic                                       l15_ret_val_i,
    input  l15_proto_pkg::rtntype_t                    l15_ret_type_i,
    input  cache_geom_pkg::ret_addr_u                  l15_ret_addr_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_ret_data_0_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_ret_data_1_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_ret_data_2_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_ret_data_3_i,
    input  logic                                       l15_inval_dc_i,
    input  logic                                       l15_inval_ic_i,
    input  logic [15:4]                                l15_inval_addr_i,
    output logic                                       l15_req_ack_o,
    // cache fills, completions and invalidations
    output logic                                       ic_fill_valid_o,
    output logic [cache_geom_pkg::IC_TAG_W-1:0]        ic_fill_tag_o,
    output logic [cache_geom_pkg::IC_INDEX_W-1:0]      ic_fill_index_o,
    output logic [cache_geom_pkg::IC_LINE_W-1:0]       ic_fill_data_o,
    output logic                                       dc_ld_valid_o,
    output logic [cache_geom_pkg::DC_TAG_W-1:0]        dc_ld_tag_o,
    output logic [cache_geom_pkg::DC_INDEX_W-1:0]      dc_ld_index_o,
    output logic [cache_geom_pkg::DC_LINE_W-1:0]       dc_ld_data_o,
    output logic                                       dc_st_complete_o,
    output logic                                       dc_st_stall_o,
    output logic                                       dc_inv_valid_o,
    output logic [cache_geom_pkg::DC_INDEX_W-1:0]      dc_inv_index_o,
    output logic                                       ic_inv_valid_o,
    output logic [cache_geom_pkg::IC_INDEX_W-1:0]      ic_inv_index_o,
    output logic                                       core_int_o
);

    // request side, issues one request at a time
    l15_request_issuer i_issuer (
        .*
    );

    // return side, shares the store pulse for the stall
    l15_response_decoder i_decoder (
        .*
    );

endmodule

// ==== design/l15_proto_pkg.sv ====
package l15_proto_pkg;

    // request type towards the L1.5
    typedef logic [4:0] rqtype_t;

    localparam rqtype_t IMISS_RQ = 5'd16;
    localparam rqtype_t LOAD_RQ  = 5'd0;
    localparam rqtype_t STORE_RQ = 5'd1;

    // return type coming back from the L1.5
    typedef logic [3:0] rtntype_t;

    localparam rtntype_t LOAD_RET  = 4'd0;
    localparam rtntype_t IFILL_RET = 4'd1;
    localparam rtntype_t EVICT_REQ = 4'd3;
    localparam rtntype_t ST_ACK    = 4'd4;
    localparam rtntype_t INT_RET   = 4'd7;

    // request size codes
    typedef logic [2:0] req_size_t;

    // instruction misses fetch 4 bytes, loads a 16 byte line
    localparam req_size_t SZ_4B  = 3'd2;
    localparam req_size_t SZ_16B = 3'd7;

    // L1.5 words are big endian, the core is little endian
    function automatic logic [63:0] byte_reverse(input logic [63:0] word);
        logic [63:0] rev;
        for (int i = 0; i < 8; i++) begin
            rev[8*i +: 8] = word[8*(7-i) +: 8];
        end
        return rev;
    endfunction

endpackage

// ==== design/l15_request_issuer.sv ====
`timescale 1ns/1ps

module l15_request_issuer (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       ic_req_valid_i,
    input  logic [cache_geom_pkg::IC_BLOCK_ADDR_W-1:0] ic_req_block_addr_i,
    input  logic                                       dc_ld_valid_i,
    input  logic [cache_geom_pkg::DC_BLOCK_ADDR_W-1:0] dc_ld_block_addr_i,
    input  logic                                       dc_st_valid_i,
    input  logic [cache_geom_pkg::PHY_ADDR_W-1:0]      dc_st_addr_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0]      dc_st_data_i,
    input  l15_proto_pkg::req_size_t                   dc_st_size_i,
    input  logic                                       l15_ack_i,
    output logic                                       l15_val_o,
    output l15_proto_pkg::rqtype_t                     l15_rqtype_o,
    output l15_proto_pkg::req_size_t                   l15_size_o,
    output logic [cache_geom_pkg::PHY_ADDR_W-1:0]      l15_address_o,
    output logic [cache_geom_pkg::L15_WORD_W-1:0]      l15_data_o,
    output logic                                       l15_nc_o
);

    localparam logic [1:0] SLOT_IDLE    = 2'd0;
    localparam logic [1:0] SLOT_ARRIVED = 2'd1;
    localparam logic [1:0] SLOT_ISSUED  = 2'd2;

    logic [1:0] ic_state_q;
    logic [1:0] ic_state_d;
    logic [1:0] ld_state_q;
    logic [1:0] ld_state_d;
    logic [1:0] st_state_q;
    logic [1:0] st_state_d;

    logic [cache_geom_pkg::PHY_ADDR_W-1:0] ic_addr_q;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] ic_addr_d;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] ld_addr_q;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] ld_addr_d;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] st_addr_q;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] st_addr_d;
    logic [cache_geom_pkg::L15_WORD_W-1:0] st_data_q;
    logic [cache_geom_pkg::L15_WORD_W-1:0] st_data_d;
    l15_proto_pkg::req_size_t              st_size_q;
    l15_proto_pkg::req_size_t              st_size_d;

    logic                                  issue;
    l15_proto_pkg::rqtype_t                rqtype_d;
    l15_proto_pkg::req_size_t              size_d;
    logic [cache_geom_pkg::PHY_ADDR_W-1:0] address_d;
    logic [cache_geom_pkg::L15_WORD_W-1:0] data_d;

    // a new pulse always wins, even over the ack of an issued slot
    function automatic logic [1:0] slot_next(input logic [1:0] cur, input logic pulse,
                                             input logic ack);
        if (pulse) begin
            return SLOT_ARRIVED;
        end
        if (ack && cur == SLOT_ISSUED) begin
            return SLOT_IDLE;
        end
        return cur;
    endfunction

    // capture, latest pulse overwrites the slot
    assign ic_addr_d = ic_req_valid_i ?
        {ic_req_block_addr_i, {cache_geom_pkg::IC_OFFSET_W{1'b0}}} : ic_addr_q;
    assign ld_addr_d = dc_ld_valid_i ?
        {dc_ld_block_addr_i, {cache_geom_pkg::DC_OFFSET_W{1'b0}}} : ld_addr_q;
    assign st_addr_d = dc_st_valid_i ? dc_st_addr_i : st_addr_q;
    assign st_data_d = dc_st_valid_i ? l15_proto_pkg::byte_reverse(dc_st_data_i) : st_data_q;
    assign st_size_d = dc_st_valid_i ? dc_st_size_i : st_size_q;

    always_comb begin
        ic_state_d = slot_next(ic_state_q, ic_req_valid_i, l15_ack_i);
        ld_state_d = slot_next(ld_state_q, dc_ld_valid_i, l15_ack_i);
        st_state_d = slot_next(st_state_q, dc_st_valid_i, l15_ack_i);
        issue      = 1'b0;
        rqtype_d   = l15_rqtype_o;
        size_d     = l15_size_o;
        address_d  = l15_address_o;
        data_d     = l15_data_o;
        // pick only while nothing is in flight, which also leaves a gap after each ack
        if (!l15_val_o) begin
            if (ic_state_d == SLOT_ARRIVED) begin
                ic_state_d = SLOT_ISSUED;
                issue      = 1'b1;
                rqtype_d   = l15_proto_pkg::IMISS_RQ;
                size_d     = l15_proto_pkg::SZ_4B;
                address_d  = ic_addr_d;
                data_d     = '0;
            end else if (ld_state_d == SLOT_ARRIVED) begin
                ld_state_d = SLOT_ISSUED;
                issue      = 1'b1;
                rqtype_d   = l15_proto_pkg::LOAD_RQ;
                size_d     = l15_proto_pkg::SZ_16B;
                address_d  = ld_addr_d;
                data_d     = '0;
            end else if (st_state_d == SLOT_ARRIVED) begin
                st_state_d = SLOT_ISSUED;
                issue      = 1'b1;
                rqtype_d   = l15_proto_pkg::STORE_RQ;
                size_d     = st_size_d;
                address_d  = st_addr_d;
                data_d     = st_data_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ic_state_q <= SLOT_IDLE;
            ld_state_q <= SLOT_IDLE;
            st_state_q <= SLOT_IDLE;
            l15_val_o  <= 1'b0;
        end else begin
            ic_state_q <= ic_state_d;
            ld_state_q <= ld_state_d;
            st_state_q <= st_state_d;
            // held until the L1.5 takes it
            l15_val_o  <= issue || (l15_val_o && !l15_ack_i);
        end
    end

    always_ff @(posedge clk) begin
        ic_addr_q     <= ic_addr_d;
        ld_addr_q     <= ld_addr_d;
        st_addr_q     <= st_addr_d;
        st_data_q     <= st_data_d;
        st_size_q     <= st_size_d;
        l15_rqtype_o  <= rqtype_d;
        l15_size_o    <= size_d;
        l15_address_o <= address_d;
        l15_data_o    <= data_d;
    end

    // top address bit selects the non-cacheable space
    assign l15_nc_o = l15_address_o[cache_geom_pkg::PHY_ADDR_W-1];

endmodule

// ==== design/l15_response_decoder.sv ====
`timescale 1ns/1ps

module l15_response_decoder (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  dc_st_valid_i,
    input  logic                                  l15_ret_val_i,
    input  l15_proto_pkg::rtntype_t               l15_ret_type_i,
    input  cache_geom_pkg::ret_addr_u             l15_ret_addr_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0] l15_ret_data_0_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0] l15_ret_data_1_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0] l15_ret_data_2_i,
    input  logic [cache_geom_pkg::L15_WORD_W-1:0] l15_ret_data_3_i,
    input  logic                                  l15_inval_dc_i,
    input  logic                                  l15_inval_ic_i,
    input  logic [15:4]                           l15_inval_addr_i,
    output logic                                  l15_req_ack_o,
    output logic                                  ic_fill_valid_o,
    output logic [cache_geom_pkg::IC_TAG_W-1:0]   ic_fill_tag_o,
    output logic [cache_geom_pkg::IC_INDEX_W-1:0] ic_fill_index_o,
    output logic [cache_geom_pkg::IC_LINE_W-1:0]  ic_fill_data_o,
    output logic                                  dc_ld_valid_o,
    output logic [cache_geom_pkg::DC_TAG_W-1:0]   dc_ld_tag_o,
    output logic [cache_geom_pkg::DC_INDEX_W-1:0] dc_ld_index_o,
    output logic [cache_geom_pkg::DC_LINE_W-1:0]  dc_ld_data_o,
    output logic                                  dc_st_complete_o,
    output logic                                  dc_st_stall_o,
    output logic                                  dc_inv_valid_o,
    output logic [cache_geom_pkg::DC_INDEX_W-1:0] dc_inv_index_o,
    output logic                                  ic_inv_valid_o,
    output logic [cache_geom_pkg::IC_INDEX_W-1:0] ic_inv_index_o,
    output logic                                  core_int_o
);

    logic dc_inv_hit;
    logic ic_inv_hit;
    logic int_ret;
    logic dc_rearm_q;
    logic ic_rearm_q;
    logic st_busy_q;

    // returns are never back-pressured
    assign l15_req_ack_o = l15_ret_val_i;

    always_comb begin
        ic_fill_valid_o  = 1'b0;
        dc_ld_valid_o    = 1'b0;
        dc_st_complete_o = 1'b0;
        dc_inv_hit       = 1'b0;
        ic_inv_hit       = 1'b0;
        int_ret          = 1'b0;
        if (l15_ret_val_i) begin
            case (l15_ret_type_i)
                l15_proto_pkg::IFILL_RET: ic_fill_valid_o = 1'b1;
                l15_proto_pkg::LOAD_RET:  dc_ld_valid_o = 1'b1;
                l15_proto_pkg::ST_ACK: begin
                    // a store ack may carry an invalidation too
                    dc_st_complete_o = 1'b1;
                    dc_inv_hit       = l15_inval_dc_i;
                    ic_inv_hit       = l15_inval_ic_i;
                end
                l15_proto_pkg::EVICT_REQ: begin
                    dc_inv_hit = l15_inval_dc_i;
                    ic_inv_hit = l15_inval_ic_i;
                end
                l15_proto_pkg::INT_RET:   int_ret = 1'b1;
                default: ;
            endcase
        end
    end

    // same address word, read through either cache's view
    assign ic_fill_tag_o   = l15_ret_addr_i.ic.tag;
    assign ic_fill_index_o = l15_ret_addr_i.ic.index;
    assign dc_ld_tag_o     = l15_ret_addr_i.dc.tag;
    assign dc_ld_index_o   = l15_ret_addr_i.dc.index;

    assign ic_fill_data_o = {l15_proto_pkg::byte_reverse(l15_ret_data_3_i),
                             l15_proto_pkg::byte_reverse(l15_ret_data_2_i),
                             l15_proto_pkg::byte_reverse(l15_ret_data_1_i),
                             l15_proto_pkg::byte_reverse(l15_ret_data_0_i)};
    assign dc_ld_data_o   = {l15_proto_pkg::byte_reverse(l15_ret_data_1_i),
                             l15_proto_pkg::byte_reverse(l15_ret_data_0_i)};

    // at most one invalidation per cache in two consecutive cycles
    assign dc_inv_valid_o = dc_inv_hit & ~dc_rearm_q;
    assign ic_inv_valid_o = ic_inv_hit & ~ic_rearm_q;
    assign dc_inv_index_o = l15_inval_addr_i[cache_geom_pkg::DC_INDEX_W+3:4];
    assign ic_inv_index_o = l15_inval_addr_i[cache_geom_pkg::IC_INDEX_W+3:4];

    // stall from the store pulse through its ack
    assign dc_st_stall_o = st_busy_q | dc_st_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dc_rearm_q <= 1'b0;
            ic_rearm_q <= 1'b0;
            st_busy_q  <= 1'b0;
            core_int_o <= 1'b0;
        end else begin
            dc_rearm_q <= dc_inv_valid_o;
            ic_rearm_q <= ic_inv_valid_o;
            // a new store in the ack cycle keeps the stall up
            if (dc_st_valid_i) begin
                st_busy_q <= 1'b1;
            end else if (dc_st_complete_o) begin
                st_busy_q <= 1'b0;
            end
            core_int_o <= int_ret & ~core_int_o;
        end
    end

endmodule

// ==== sim/l15_bridge_asserts.sv ====
`timescale 1ns/1ps

module l15_bridge_asserts (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  l15_val_o,
    input logic                                  l15_ack_i,
    input l15_proto_pkg::rqtype_t                l15_rqtype_o,
    input l15_proto_pkg::req_size_t              l15_size_o,
    input logic [cache_geom_pkg::PHY_ADDR_W-1:0] l15_address_o,
    input logic [cache_geom_pkg::L15_WORD_W-1:0] l15_data_o,
    input logic                                  core_int_o
);

    // request held without ack keeps every field
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val_o && !l15_ack_i |=> l15_val_o && $stable(l15_rqtype_o) &&
        $stable(l15_size_o) && $stable(l15_address_o) && $stable(l15_data_o))
        else $error("request changed while waiting for ack");

    val_drops: assert property (@(posedge clk) disable iff (!rst_n)
        l15_val_o && l15_ack_i |=> !l15_val_o)
        else $error("valid stayed high after ack");

    int_single: assert property (@(posedge clk) disable iff (!rst_n)
        core_int_o |=> !core_int_o)
        else $error("interrupt pulse longer than one cycle");

endmodule

// top level holds both the issuer and the decoder signals
bind l15_bridge_top l15_bridge_asserts i_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .l15_val_o     (l15_val_o),
    .l15_ack_i     (l15_ack_i),
    .l15_rqtype_o  (l15_rqtype_o),
    .l15_size_o    (l15_size_o),
    .l15_address_o (l15_address_o),
    .l15_data_o    (l15_data_o),
    .core_int_o    (core_int_o)
);

// ==== sim/l15_bridge_tb.sv ====
`timescale 1ns/1ps

module l15_bridge_tb;

    logic clk;
    logic rst_n;
    logic ic_req_valid_i, dc_ld_valid_i, dc_st_valid_i, l15_ack_i;
    logic [34:0] ic_req_block_addr_i;
    logic [35:0] dc_ld_block_addr_i;
    logic [39:0] dc_st_addr_i, l15_address_o, l15_ret_addr_i;
    logic [63:0] dc_st_data_i, l15_data_o;
    logic [63:0] l15_ret_data_0_i, l15_ret_data_1_i, l15_ret_data_2_i, l15_ret_data_3_i;
    l15_proto_pkg::req_size_t dc_st_size_i, l15_size_o;
    l15_proto_pkg::rqtype_t   l15_rqtype_o;
    l15_proto_pkg::rtntype_t  l15_ret_type_i;
    logic l15_val_o, l15_nc_o, l15_ret_val_i, l15_inval_dc_i, l15_inval_ic_i, l15_req_ack_o;
    logic [15:4] l15_inval_addr_i;
    logic ic_fill_valid_o, dc_ld_valid_o, dc_st_complete_o, dc_st_stall_o;
    logic dc_inv_valid_o, ic_inv_valid_o, core_int_o;
    logic [27:0] ic_fill_tag_o, dc_ld_tag_o;
    logic [6:0] ic_fill_index_o, ic_inv_index_o;
    logic [7:0] dc_ld_index_o, dc_inv_index_o;
    logic [255:0] ic_fill_data_o;
    logic [127:0] dc_ld_data_o;

    // reference model state
    bit ic_pend, ld_pend, st_pend, prev_val, run;
    bit st_busy_m, dc_rearm_m, ic_rearm_m, int_m, dc_inv_e, ic_inv_e;
    logic [39:0] ic_exp_addr, ld_exp_addr, st_exp_addr;
    logic [63:0] st_exp_data;
    l15_proto_pkg::req_size_t st_exp_size;
    l15_proto_pkg::rtntype_t ret_q[$];
    int unsigned ack_delay;
    int cycles;

    l15_bridge_top i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [63:0] swap_bytes(input logic [63:0] w);
        return {<<8{w}};
    endfunction

    // anything still in flight in the model or on the return port
    function automatic bit outstanding();
        return ic_pend || ld_pend || st_pend || l15_val_o || ret_q.size() != 0 ||
               l15_ret_val_i || st_busy_m || int_m;
    endfunction

    task automatic fail_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_rqtype(input l15_proto_pkg::rqtype_t got,
                                input l15_proto_pkg::rqtype_t exp);
        if (got !== exp) begin
            $display("Error at %0t: request type %0d, expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_size(input l15_proto_pkg::req_size_t got,
                              input l15_proto_pkg::req_size_t exp);
        if (got !== exp) begin
            $display("Error at %0t: request size %0d, expected %0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input logic [cache_geom_pkg::PHY_ADDR_W-1:0] got,
                              input logic [cache_geom_pkg::PHY_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: address %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(input logic [cache_geom_pkg::L15_WORD_W-1:0] got,
                              input logic [cache_geom_pkg::L15_WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: store data %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_ic_line(input logic [cache_geom_pkg::IC_LINE_W-1:0] got,
                                 input logic [cache_geom_pkg::IC_LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: fill line %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_dc_line(input logic [cache_geom_pkg::DC_LINE_W-1:0] got,
                                 input logic [cache_geom_pkg::DC_LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: load line %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_tag(input logic [27:0] got, input logic [27:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_index(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    // first cycle of a request must match the highest pending slot
    task automatic check_request();
        logic [39:0] ea;
        if (l15_val_o && !prev_val) begin
            if (ic_pend) begin
                ea = ic_exp_addr;
                ic_pend = 0;
                check_rqtype(l15_rqtype_o, l15_proto_pkg::IMISS_RQ);
                check_size(l15_size_o, l15_proto_pkg::SZ_4B);
            end else if (ld_pend) begin
                ea = ld_exp_addr;
                ld_pend = 0;
                check_rqtype(l15_rqtype_o, l15_proto_pkg::LOAD_RQ);
                check_size(l15_size_o, l15_proto_pkg::SZ_16B);
            end else if (st_pend) begin
                ea = st_exp_addr;
                st_pend = 0;
                check_rqtype(l15_rqtype_o, l15_proto_pkg::STORE_RQ);
                check_size(l15_size_o, st_exp_size);
                check_word(l15_data_o, st_exp_data);
            end else begin
                $display("Request issued while no core request was pending");
                fail_run();
            end
            check_addr(l15_address_o, ea);
            check_bit(l15_nc_o, ea[39], "nc flag");
        end
        prev_val = l15_val_o;
    endtask

    task automatic check_return();
        logic rv;
        logic inv_kind;
        rv = l15_ret_val_i;
        inv_kind = rv && (l15_ret_type_i == 4'd4 || l15_ret_type_i == 4'd3);
        dc_inv_e = inv_kind && l15_inval_dc_i && !dc_rearm_m;
        ic_inv_e = inv_kind && l15_inval_ic_i && !ic_rearm_m;
        check_bit(l15_req_ack_o, rv, "return ack");
        check_bit(ic_fill_valid_o, rv && l15_ret_type_i == 4'd1, "fill valid");
        check_bit(dc_ld_valid_o, rv && l15_ret_type_i == 4'd0, "load valid");
        check_bit(dc_st_complete_o, rv && l15_ret_type_i == 4'd4, "store complete");
        check_bit(dc_st_stall_o, st_busy_m || dc_st_valid_i, "store stall");
        check_bit(dc_inv_valid_o, dc_inv_e, "dcache invalidate");
        check_bit(ic_inv_valid_o, ic_inv_e, "icache invalidate");
        check_bit(core_int_o, int_m, "interrupt");
        if (ic_fill_valid_o) begin
            check_tag(ic_fill_tag_o, l15_ret_addr_i[39:12], "fill tag");
            check_index({1'b0, ic_fill_index_o}, {1'b0, l15_ret_addr_i[11:5]}, "fill index");
            check_ic_line(ic_fill_data_o, {swap_bytes(l15_ret_data_3_i),
                swap_bytes(l15_ret_data_2_i), swap_bytes(l15_ret_data_1_i),
                swap_bytes(l15_ret_data_0_i)});
        end
        if (dc_ld_valid_o) begin
            check_tag(dc_ld_tag_o, l15_ret_addr_i[39:12], "load tag");
            check_index(dc_ld_index_o, l15_ret_addr_i[11:4], "load index");
            check_dc_line(dc_ld_data_o, {swap_bytes(l15_ret_data_1_i),
                swap_bytes(l15_ret_data_0_i)});
        end
        if (dc_inv_e) begin
            check_index(dc_inv_index_o, l15_inval_addr_i[11:4], "dcache inv index");
        end
        if (ic_inv_e) begin
            check_index({1'b0, ic_inv_index_o}, {1'b0, l15_inval_addr_i[10:4]}, "icache inv index");
        end
    endtask

    // inputs seen now are what the DUT samples at the next rising edge
    task automatic advance_model();
        if (ic_req_valid_i) begin
            ic_pend = 1;
            ic_exp_addr = {ic_req_block_addr_i, 5'b0};
        end
        if (dc_ld_valid_i) begin
            ld_pend = 1;
            ld_exp_addr = {dc_ld_block_addr_i, 4'b0};
        end
        if (dc_st_valid_i) begin
            st_pend = 1;
            st_exp_addr = dc_st_addr_i;
            st_exp_data = swap_bytes(dc_st_data_i);
            st_exp_size = dc_st_size_i;
        end
        if (l15_val_o && l15_ack_i) begin
            if (l15_rqtype_o == 5'd16) ret_q.push_back(4'd1);
            else if (l15_rqtype_o == 5'd0) ret_q.push_back(4'd0);
            else ret_q.push_back(4'd4);
        end
        if (dc_st_valid_i) st_busy_m = 1;
        else if (l15_ret_val_i && l15_ret_type_i == 4'd4) st_busy_m = 0;
        dc_rearm_m = dc_inv_e;
        ic_rearm_m = ic_inv_e;
        int_m = l15_ret_val_i && l15_ret_type_i == 4'd7 && !int_m;
    endtask

    task automatic drive_next();
        ic_req_valid_i      <= run && ($urandom % 6 == 0);
        ic_req_block_addr_i <= 35'({$urandom, $urandom});
        dc_ld_valid_i       <= run && ($urandom % 6 == 0);
        dc_ld_block_addr_i  <= 36'({$urandom, $urandom});
        dc_st_valid_i       <= run && ($urandom % 6 == 0);
        dc_st_addr_i        <= 40'({$urandom, $urandom});
        dc_st_data_i        <= {$urandom, $urandom};
        dc_st_size_i        <= 3'($urandom % 8);
        // a fresh ack delay is drawn until the request shows up
        if (l15_ack_i || !l15_val_o) begin
            l15_ack_i <= 1'b0;
            ack_delay = $urandom % 6;
        end else if (ack_delay == 0) begin
            l15_ack_i <= 1'b1;
        end else begin
            ack_delay--;
        end
        l15_ret_val_i <= 1'b0;
        if (ret_q.size() != 0 && $urandom % 2 == 1) begin
            l15_ret_val_i  <= 1'b1;
            l15_ret_type_i <= ret_q.pop_front();
        end else if (run && $urandom % 8 == 0) begin
            // unsolicited evictions and interrupts
            l15_ret_val_i  <= 1'b1;
            l15_ret_type_i <= ($urandom % 2 == 1) ? 4'd3 : 4'd7;
        end
        l15_ret_addr_i   <= 40'({$urandom, $urandom});
        l15_ret_data_0_i <= {$urandom, $urandom};
        l15_ret_data_1_i <= {$urandom, $urandom};
        l15_ret_data_2_i <= {$urandom, $urandom};
        l15_ret_data_3_i <= {$urandom, $urandom};
        l15_inval_dc_i   <= ($urandom % 2 == 1);
        l15_inval_ic_i   <= ($urandom % 2 == 1);
        l15_inval_addr_i <= 12'($urandom);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_request();
            check_return();
            advance_model();
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            drive_next();
        end
    end

    initial begin
        void'($urandom(32'hcf72));
        clk = 0;
        rst_n = 0;
        run = 0;
        ic_req_valid_i = 0;
        ic_req_block_addr_i = '0;
        dc_ld_valid_i = 0;
        dc_ld_block_addr_i = '0;
        dc_st_valid_i = 0;
        dc_st_addr_i = '0;
        dc_st_data_i = '0;
        dc_st_size_i = '0;
        l15_ack_i = 0;
        l15_ret_val_i = 0;
        l15_ret_type_i = '0;
        l15_ret_addr_i = '0;
        l15_ret_data_0_i = '0;
        l15_ret_data_1_i = '0;
        l15_ret_data_2_i = '0;
        l15_ret_data_3_i = '0;
        l15_inval_dc_i = 0;
        l15_inval_ic_i = 0;
        l15_inval_addr_i = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run = 1;
        cycles = 0;
        while (cycles < 4000) begin
            @(posedge clk);
            cycles++;
        end
        run <= 1'b0;
        // let pending slots and queued returns drain
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (outstanding() && cycles < 500);
        if (outstanding()) begin
            $display("Timeout while waiting for outstanding requests to drain");
            fail_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
